// ==== scalable_proc_pkg.sv ====
`default_nettype none

package scalable_proc_pkg;

    // Sizing and timing
    localparam int NUM_UNITS      = 2;
    localparam int ROM_ADDR_BITS  = 3;
    localparam int UART_PRESCALER = 8;
    // Ten bits per character plus one spare bit time
    localparam int CHAR_INTERVAL  = UART_PRESCALER * 11;
    localparam int CHARS_PER_UNIT = 8;

    // Data types
    typedef logic [31:0]               word_t;
    typedef logic [ROM_ADDR_BITS-1:0]  rom_addr_t;
    typedef logic [3:0]                nibble_t;
    typedef logic [NUM_UNITS*32-1:0]   lane_t;

    // Symbol from the sequencer to the transmitter
    typedef struct packed {
        logic    delim;
        nibble_t nibble;
    } tx_sym_t;

    typedef enum logic [2:0] {
        INIT, LOAD_START, LOAD_SHIFT, PROC_START,
        PROC_WAIT, SEND_START, SEND_WAIT, SEND_DELIM
    } seq_state_e;

    // CRC-32 shifted MSB first with no final XOR
    localparam word_t CRC_POLY = 32'h04C11DB7;
    localparam word_t CRC_INIT = 32'hFFFFFFFF;

endpackage

`default_nettype wire

// ==== rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom
    import scalable_proc_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  logic      rd_en,
    input  rom_addr_t addr,
    output logic      rd_stb,
    output word_t     rd_word
);

    word_t mem [0:(1 << ROM_ADDR_BITS)-1];

    initial begin
        $readmemh("rom_image.hex", mem);
    end

    // Registered read port
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_word <= mem[addr];
        end
    end

    // Data valid one cycle after the read strobe
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rd_stb <= 1'b0;
        end else begin
            rd_stb <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== processing_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module processing_unit
    import scalable_proc_pkg::*;
(
    input  logic  CLK,
    input  logic  RST,
    input  logic  start,
    input  word_t data,
    output logic  done,
    output word_t result
);

    word_t      data_sr;
    word_t      crc;
    word_t      crc_next;
    logic       fb;
    logic       busy;
    logic [4:0] bit_cnt;
    logic       last_bit;

    // One LFSR step on the current MSB of the data
    assign fb       = crc[31] ^ data_sr[31];
    assign crc_next = {crc[30:0], 1'b0} ^ (fb ? CRC_POLY : '0);
    assign last_bit = busy && (bit_cnt == 5'd31);

    // Start is dropped while a job runs
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= last_bit;
            if (!busy) begin
                busy    <= start;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                busy    <= !last_bit;
            end
        end
    end

    // Datapath
    always_ff @(posedge CLK) begin
        if (!busy && start) begin
            data_sr <= data;
            crc     <= CRC_INIT;
        end else if (busy) begin
            data_sr <= data_sr << 1;
            crc     <= crc_next;
        end
        if (last_bit) begin
            result <= crc_next;
        end
    end

endmodule

`default_nettype wire

// ==== proc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module proc_sequencer
    import scalable_proc_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  logic      unit_done,
    input  nibble_t   cur_nibble,
    output logic      rom_stb,
    output rom_addr_t rom_addr,
    output logic      start,
    output logic      out_shift,
    output logic      sym_stb,
    output tx_sym_t   sym
);

    // Down counter with its MSB as the underflow flag
    localparam int CNT_W  = $clog2(NUM_UNITS * CHARS_PER_UNIT) + 1;
    localparam int PACE_W = $clog2(CHAR_INTERVAL);

    seq_state_e        state;
    logic [CNT_W-1:0]  cnt;
    logic              cnt_last;
    logic [PACE_W-1:0] pace_cnt;
    logic              pace;

    assign cnt_last = cnt[CNT_W-1];

    // ========================================================================
    // State register
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= INIT;
        end else begin
            case (state)
                INIT:       state <= LOAD_START;
                LOAD_START: state <= LOAD_SHIFT;
                LOAD_SHIFT: if (cnt_last) state <= PROC_START;
                PROC_START: state <= PROC_WAIT;
                PROC_WAIT:  if (unit_done) state <= SEND_START;
                SEND_START: state <= SEND_WAIT;
                SEND_WAIT:  if (pace && cnt_last) state <= SEND_DELIM;
                SEND_DELIM: if (pace) state <= INIT;
                default:    state <= INIT;
            endcase
        end
    end

    // Words to load, then characters to send
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            cnt <= '0;
        end else begin
            case (state)
                LOAD_START: cnt <= CNT_W'(NUM_UNITS - 2);
                SEND_START: cnt <= CNT_W'(NUM_UNITS * CHARS_PER_UNIT - 2);
                SEND_WAIT: begin
                    if (pace && !cnt_last) begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    // Saturates once negative
                    if (!cnt_last) begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // ========================================================================
    // Free-running character pacing
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            pace_cnt <= PACE_W'(CHAR_INTERVAL - 1);
        end else if (pace) begin
            pace_cnt <= PACE_W'(CHAR_INTERVAL - 1);
        end else begin
            pace_cnt <= pace_cnt - 1'b1;
        end
    end

    assign pace = (pace_cnt == '0);

    // ========================================================================
    // ROM address steps once per load cycle and wraps at the end of the ROM
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rom_addr <= '0;
        end else if (state == LOAD_SHIFT) begin
            rom_addr <= rom_addr + 1'b1;
        end
    end

    // Unit start pulse
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            start <= 1'b0;
        end else begin
            start <= (state == PROC_START);
        end
    end

    assign rom_stb   = (state == LOAD_SHIFT);
    assign out_shift = (state == SEND_WAIT) && pace;
    assign sym_stb   = pace && ((state == SEND_WAIT) || (state == SEND_DELIM));

    // Data nibble while sending, delimiter otherwise
    always_comb begin
        sym.delim  = (state != SEND_WAIT);
        sym.nibble = (state == SEND_WAIT) ? cur_nibble : '0;
    end

endmodule

`default_nettype wire

// ==== hex_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_uart_tx
    import scalable_proc_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    sym_stb,
    input  tx_sym_t sym,
    output logic    tx
);

    localparam int PRE_W = $clog2(UART_PRESCALER);

    logic [7:0]       ascii;
    logic [9:0]       frame;
    logic             busy;
    logic [PRE_W-1:0] pre_cnt;
    logic [3:0]       bit_cnt;
    logic             bit_end;

    // ========================================================================
    // Symbol to ASCII
    always_comb begin
        if (sym.delim) begin
            // Newline
            ascii = 8'h0A;
        end else if (sym.nibble < 4'd10) begin
            ascii = 8'h30 + {4'h0, sym.nibble};
        end else begin
            // Upper case A to F
            ascii = 8'h37 + {4'h0, sym.nibble};
        end
    end

    // ========================================================================
    // Bit timing
    assign bit_end = busy && (pre_cnt == PRE_W'(UART_PRESCALER - 1));

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            pre_cnt <= '0;
        end else if (sym_stb || bit_end) begin
            pre_cnt <= '0;
        end else if (busy) begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (sym_stb) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            // Stop bit done
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Frame shifter with the start bit at the bottom
    // Line rests high
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            frame <= '1;
        end else if (sym_stb) begin
            frame <= {1'b1, ascii, 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    assign tx = frame[0];

endmodule

`default_nettype wire

// ==== scalable_proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module scalable_proc
    import scalable_proc_pkg::*;
(
    input  logic CLK,
    input  logic RST,
    output logic tx
);

    logic                 rom_stb;
    rom_addr_t            rom_addr;
    logic                 rd_stb;
    word_t                rd_word;
    logic                 start;
    logic [NUM_UNITS-1:0] unit_done;
    lane_t                unit_result;
    lane_t                in_sreg;
    lane_t                out_sreg;
    logic                 out_shift;
    nibble_t              cur_nibble;
    logic                 sym_stb;
    tx_sym_t              sym;

    // ========================================================================
    // ROM and input shift register
    rom u_rom (
        .CLK     (CLK),
        .RST     (RST),
        .rd_en   (rom_stb),
        .addr    (rom_addr),
        .rd_stb  (rd_stb),
        .rd_word (rd_word)
    );

    // New word enters the low slot, older words move up
    always_ff @(posedge CLK) begin
        if (rd_stb) begin
            in_sreg <= lane_t'({in_sreg, rd_word});
        end
    end

    // ========================================================================
    // Processing units
    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        processing_unit u_unit (
            .CLK    (CLK),
            .RST    (RST),
            .start  (start),
            .data   (in_sreg[i*32 +: 32]),
            .done   (unit_done[i]),
            .result (unit_result[i*32 +: 32])
        );
    end

    // ========================================================================
    // Output shift register sends its top nibble first
    always_ff @(posedge CLK) begin
        if (unit_done[0]) begin
            out_sreg <= unit_result;
        end else if (out_shift) begin
            out_sreg <= out_sreg << 4;
        end
    end

    assign cur_nibble = out_sreg[$bits(lane_t)-1 -: 4];

    // ========================================================================
    // Control and UART
    proc_sequencer u_seq (
        .CLK        (CLK),
        .RST        (RST),
        .unit_done  (unit_done[0]),
        .cur_nibble (cur_nibble),
        .rom_stb    (rom_stb),
        .rom_addr   (rom_addr),
        .start      (start),
        .out_shift  (out_shift),
        .sym_stb    (sym_stb),
        .sym        (sym)
    );

    hex_uart_tx u_tx (
        .CLK     (CLK),
        .RST     (RST),
        .sym_stb (sym_stb),
        .sym     (sym),
        .tx      (tx)
    );

endmodule

`default_nettype wire

// ==== scalable_proc_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module scalable_proc_chk
    import scalable_proc_pkg::*;
(
    input logic                 CLK,
    input logic                 RST,
    input logic                 tx,
    input logic                 start,
    input logic                 unit0_busy,
    input logic                 sym_stb,
    input logic [NUM_UNITS-1:0] unit_done,
    input seq_state_e           seq_state
);

    // Number of assertion failures
    int fail_cnt;

    // Units run in lockstep
    a_done_equal: assert property (
        @(posedge CLK) disable iff (RST) (unit_done == '0) || (unit_done == '1)
    ) else begin
        $error("processing unit done lines differ");
        fail_cnt++;
    end

    a_sym_in_send: assert property (
        @(posedge CLK) disable iff (RST)
        sym_stb |-> ((seq_state == SEND_WAIT) || (seq_state == SEND_DELIM))
    ) else begin
        $error("symbol strobe outside the send states");
        fail_cnt++;
    end

    // Line idles high in reset
    a_tx_idle_in_reset: assert property (
        @(posedge CLK) RST |-> tx
    ) else begin
        $error("tx low while reset is active");
        fail_cnt++;
    end

    a_start_not_busy: assert property (
        @(posedge CLK) disable iff (RST) start |-> !unit0_busy
    ) else begin
        $error("start pulse while unit 0 is busy");
        fail_cnt++;
    end

endmodule

bind scalable_proc scalable_proc_chk u_chk (
    .CLK        (CLK),
    .RST        (RST),
    .tx         (tx),
    .start      (start),
    .unit0_busy (g_unit[0].u_unit.busy),
    .sym_stb    (sym_stb),
    .unit_done  (unit_done),
    .seq_state  (u_seq.state)
);

`default_nettype wire

// ==== scalable_proc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scalable_proc_tb
    import scalable_proc_pkg::*;
();

    localparam int    CLK_HALF    = 20;
    localparam int    FRAME_CHARS = NUM_UNITS * CHARS_PER_UNIT;
    localparam string TRACE_FILE  = "scalable_proc_trace.txt";

    logic CLK;
    logic RST;
    logic tx;

    // UART line decoder state
    logic       rx_busy;
    int         rx_cnt;
    logic [7:0] rx_bits;
    int         idle_cnt;
    bit         after_reset;
    logic [7:0] rx_char_q [$];
    bit         rx_stop_q [$];
    int         rx_idle_q [$];

    // Test bookkeeping
    string test_name;
    int    test_errs;
    int    total_errs;
    int    tests_run;
    int    tests_failed;
    int    chars_checked;
    int    frame_chars;
    int    limit_cycles;

    scalable_proc uut (
        .CLK (CLK),
        .RST (RST),
        .tx  (tx)
    );

    initial CLK = 1'b0;
    always #CLK_HALF CLK = ~CLK;

    // ========================================================================
    // UART line decoder sampling on the falling clock edge near mid-bit
    always @(negedge CLK) begin
        if (RST) begin
            rx_busy     = 1'b0;
            idle_cnt    = 0;
            after_reset = 1'b1;
        end else if (!rx_busy) begin
            if (tx == 1'b0) begin
                // Falling start edge
                rx_busy = 1'b1;
                rx_cnt  = 0;
            end else if (after_reset) begin
                idle_cnt++;
            end
        end else begin
            rx_cnt++;
            if (rx_cnt % UART_PRESCALER == UART_PRESCALER / 2) begin
                if (rx_cnt / UART_PRESCALER == 9) begin
                    // Stop bit
                    rx_char_q.push_back(rx_bits);
                    rx_stop_q.push_back(tx);
                    rx_idle_q.push_back(after_reset ? idle_cnt : -1);
                    after_reset = 1'b0;
                    rx_busy     = 1'b0;
                end else if (rx_cnt / UART_PRESCALER >= 1) begin
                    // Data LSB first
                    rx_bits = {tx, rx_bits[7:1]};
                end
            end
        end
    end

    // ========================================================================
    // Bookkeeping
    task automatic note_error();
        test_errs++;
        total_errs++;
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errs == 0) begin
                $display("Test %s ok", test_name);
            end else begin
                tests_failed++;
                $display("Test %s failed with %0d errors", test_name, test_errs);
            end
        end
        test_name = "";
    endtask

    task automatic open_test(input string name);
        close_test();
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_run(input bit ok);
        if (ok) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // ========================================================================
    // Stimulus and checks
    task automatic apply_reset(input int cycles);
        @(posedge CLK);
        RST <= 1'b1;
        repeat (cycles) @(posedge CLK);
        RST <= 1'b0;
        rx_char_q.delete();
        rx_stop_q.delete();
        rx_idle_q.delete();
        frame_chars = 0;
    endtask

    task automatic check_char(input logic [7:0] exp);
        logic [7:0] got;
        bit         stop_ok;
        int         idle;
        while (rx_char_q.size() == 0) begin
            @(posedge CLK);
        end
        got     = rx_char_q.pop_front();
        stop_ok = rx_stop_q.pop_front();
        idle    = rx_idle_q.pop_front();
        chars_checked++;
        if (idle >= 0) begin
            assert (idle >= CHAR_INTERVAL) else begin
                $display("First start bit came %0d cycles after reset, expected %0d or more",
                         idle, CHAR_INTERVAL);
                note_error();
            end
        end
        assert (stop_ok) else begin
            $display("Missing stop bit on received character %0d", chars_checked);
            note_error();
        end
        assert (got === exp) else begin
            $display("Error tx char expected 0x%02h received 0x%02h", exp, got);
            note_error();
        end
        if (got == 8'h0A) begin
            assert (frame_chars == FRAME_CHARS) else begin
                $display("Newline came after %0d hex characters instead of %0d",
                         frame_chars, FRAME_CHARS);
                note_error();
            end
            frame_chars = 0;
        end else begin
            frame_chars++;
        end
    endtask

    // First pass over the trace to size the watchdog
    task automatic count_trace(output int n_chars, output int n_frames, output int n_rst);
        int    fd;
        int    value;
        string tok;
        string rest;
        n_chars  = 0;
        n_frames = 0;
        n_rst    = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                case (tok)
                    "#": void'($fgets(rest, fd));
                    "T": void'($fscanf(fd, "%s", rest));
                    "R": begin
                        void'($fscanf(fd, "%d", value));
                        n_rst += value;
                    end
                    "C": begin
                        void'($fscanf(fd, "%h", value));
                        n_chars++;
                        // A newline closes a frame
                        if (value == 'h0A) begin
                            n_frames++;
                        end
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
        end
    endtask

    task automatic run_trace(input int fd);
        string      tok;
        string      rest;
        int         value;
        logic [7:0] exp_char;
        while ($fscanf(fd, "%s", tok) == 1) begin
            case (tok)
                "#": void'($fgets(rest, fd));
                "T": begin
                    void'($fscanf(fd, "%s", rest));
                    open_test(rest);
                end
                "R": begin
                    void'($fscanf(fd, "%d", value));
                    apply_reset(value);
                end
                "C": begin
                    void'($fscanf(fd, "%h", exp_char));
                    check_char(exp_char);
                end
                default: begin
                    $display("Unknown trace entry %s", tok);
                    note_error();
                end
            endcase
        end
    endtask

    // ========================================================================
    // Main sequence
    initial begin
        int n_chars;
        int n_frames;
        int n_rst;
        int fd;
        RST           = 1'b1;
        test_name     = "";
        test_errs     = 0;
        total_errs    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        chars_checked = 0;
        frame_chars   = 0;
        count_trace(n_chars, n_frames, n_rst);
        // Two character intervals per character plus 200 cycles per frame
        limit_cycles = n_chars * CHAR_INTERVAL * 2 + 200 * n_frames + n_rst;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Trace file %s could not be opened", TRACE_FILE);
            note_error();
        end else begin
            run_trace(fd);
            $fclose(fd);
        end
        close_test();
        assert (chars_checked > 0) else begin
            $display("No characters were checked");
            total_errs++;
        end
        assert (uut.u_chk.fail_cnt == 0) else begin
            $display("Concurrent assertions in the checker failed %0d times",
                     uut.u_chk.fail_cnt);
            total_errs++;
        end
        $display("Tests run %0d, failed %0d, characters checked %0d, errors %0d",
                 tests_run, tests_failed, chars_checked, total_errs);
        end_run(total_errs == 0);
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge CLK);
        $display("Timeout after %0d clock cycles, the trace did not complete", limit_cycles);
        end_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== rom_image.hex ====
// One 32-bit ROM word per line, address 0 first
FFFFFFFE
FFFFFF7F
FFFFFFFF
FFFFFFF0
FFFFFFBF
FFFFFFF5
FFFFFFDF
FFFFFFEF

// ==== scalable_proc_trace.txt ====
# Columns: T <test name> | R <reset cycles> | C <expected tx character, hex ASCII>
# Several C entries may share a line, # starts a comment up to the end of the line
T reset_frame0
R 8
C 30 C 34 C 43 C 31 C 31 C 44 C 42 C 37   # word 0 CRC 04C11DB7
C 36 C 39 C 30 C 43 C 45 C 30 C 45 C 45   # word 1 CRC 690CE0EE
C 0A
T frame1_words_2_3
C 30 C 30 C 30 C 30 C 30 C 30 C 30 C 30   # word 2 CRC 00000000
C 33 C 38 C 34 C 46 C 42 C 44 C 42 C 44   # word 3 CRC 384FBDBD
C 0A
T frame2_words_4_5
C 33 C 34 C 38 C 36 C 37 C 30 C 37 C 37   # word 4 CRC 34867077
C 32 C 46 C 38 C 41 C 44 C 36 C 44 C 36   # word 5 CRC 2F8AD6D6
C 0A
T reset_mid_frame3
C 39                                      # first digit of word 6 CRC 9823B6E0
R 8
T frame0_after_reset
C 30 C 34 C 43 C 31 C 31 C 44 C 42 C 37   # word 0 again
C 36 C 39 C 30 C 43 C 45 C 30 C 45 C 45   # word 1 again
C 0A

// ==== sim.f ====
scalable_proc_pkg.sv
rom.sv
processing_unit.sv
proc_sequencer.sv
hex_uart_tx.sv
scalable_proc.sv
scalable_proc_chk.sv
scalable_proc_tb.sv
